//--- compile.f
+incdir+test
hw/simt_pkg.sv
hw/register_file.sv
hw/warp_dispatcher.sv
hw/operand_collector.sv
hw/exec_unit.sv
hw/simt_slice_top.sv
test/tb_simt_slice.sv

//--- hw/exec_unit.sv
// Execution unit
// Small input queue, per-lane ALU and registered writeback with credit return
`timescale 1ns/1ps

module exec_unit (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // From the collector
    input  logic            exec_valid_i,
    input  simt_pkg::exec_t exec_i,
    output logic            eu_credit_o,
    // Writeback and result
    output logic            wb_valid_o,
    output simt_pkg::wb_t   wb_o
);

    // ################################################
    // Input queue
    // ################################################
    simt_pkg::exec_t               queue_q [simt_pkg::EU_CREDITS];
    logic [simt_pkg::EU_PTR_W-1:0] wr_ptr_q;
    logic [simt_pkg::EU_PTR_W-1:0] rd_ptr_q;
    logic [simt_pkg::EU_CNT_W-1:0] count_q;
    logic                          pop;
    simt_pkg::exec_t               head;
    simt_pkg::lane_data_t          result;

    // Writeback stage never stalls
    assign pop         = count_q != '0;
    assign eu_credit_o = pop;
    assign head        = queue_q[rd_ptr_q];

    // ################################################
    // Lane ALU
    // ################################################
    always_comb begin
        result = '0;
        for (int l = 0; l < simt_pkg::LANES; l++) begin
            case (head.issue.inst.opcode)
                simt_pkg::OP_ADD: result[l] = head.src0_data[l] + head.src1_data[l];
                simt_pkg::OP_SUB: result[l] = head.src0_data[l] - head.src1_data[l];
                simt_pkg::OP_XOR: result[l] = head.src0_data[l] ^ head.src1_data[l];
                // Immediate plus lane number
                simt_pkg::OP_LDI: result[l] =
                    simt_pkg::REG_W'(head.issue.inst.operands.imm) + simt_pkg::REG_W'(l);
                default:          result[l] = '0;
            endcase
        end
    end

    // ################################################
    // Control state
    // ################################################
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            wb_valid_o <= 1'b0;
        end else begin
            if (exec_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({exec_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
            wb_valid_o <= pop;
        end
    end

    // Queue storage and writeback payload
    always_ff @(posedge clk_i) begin
        if (exec_valid_i) begin
            queue_q[wr_ptr_q] <= exec_i;
        end
        if (pop) begin
            wb_o <= '{wid:      head.issue.inst.wid,
                      dst:      head.issue.inst.dst,
                      act_mask: head.issue.inst.act_mask,
                      tag:      head.issue.tag,
                      data:     result};
        end
    end

endmodule

//--- hw/operand_collector.sv
// Operand collector
// Holds one instruction, fetches its sources, forwards it on execution-unit credit
`timescale 1ns/1ps

module operand_collector (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // From the dispatcher
    input  logic                issue_valid_i,
    input  simt_pkg::issue_t    issue_i,
    output logic                coll_credit_o,
    // Register file read ports
    output logic                rd_req_valid_o [simt_pkg::NUM_OPS],
    output simt_pkg::rf_req_t   rd_req_o       [simt_pkg::NUM_OPS],
    input  logic                rd_req_ready_i [simt_pkg::NUM_OPS],
    input  logic                rd_rsp_valid_i [simt_pkg::NUM_OPS],
    input  simt_pkg::lane_data_t rd_rsp_data_i [simt_pkg::NUM_OPS],
    // To the execution unit
    output logic                exec_valid_o,
    output simt_pkg::exec_t     exec_o,
    input  logic                eu_credit_i
);

    // ################################################
    // State
    // ################################################
    // Valid instruction held
    logic                            occupied_q;
    simt_pkg::issue_t                inst_q;
    // Read sent, data captured
    logic [simt_pkg::NUM_OPS-1:0]    requested_q;
    logic [simt_pkg::NUM_OPS-1:0]    ready_q;
    simt_pkg::lane_data_t            data_q  [simt_pkg::NUM_OPS];
    logic [simt_pkg::REG_IDX_W-1:0]  src_idx [simt_pkg::NUM_OPS];
    logic [simt_pkg::EU_CNT_W-1:0]   credit_q;

    logic                            accept;
    logic                            send;
    logic                            is_ldi;

    // Credit loop guarantees we are empty here
    assign accept = issue_valid_i;
    assign is_ldi = issue_i.inst.opcode == simt_pkg::OP_LDI;

    // Register view of the held instruction
    assign src_idx[0] = inst_q.inst.operands.regs.src0;
    assign src_idx[1] = inst_q.inst.operands.regs.src1;

    // ################################################
    // Read requests
    // ################################################
    for (genvar i = 0; i < simt_pkg::NUM_OPS; i++) begin : gen_req
        // One request per operand, none once data is in
        assign rd_req_valid_o[i] = occupied_q && !requested_q[i] && !ready_q[i];
        assign rd_req_o[i]       = '{wid: inst_q.inst.wid, idx: src_idx[i]};
    end

    // ################################################
    // Forwarding
    // ################################################
    assign exec_valid_o  = occupied_q && (&ready_q) && (credit_q != '0);
    assign send          = exec_valid_o;
    // Slot frees as the instruction leaves
    assign coll_credit_o = send;
    assign exec_o        = '{issue: inst_q, src0_data: data_q[0], src1_data: data_q[1]};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupied_q  <= 1'b0;
            requested_q <= '0;
            ready_q     <= '0;
            credit_q    <= simt_pkg::EU_CNT_W'(simt_pkg::EU_CREDITS);
        end else begin
            for (int i = 0; i < simt_pkg::NUM_OPS; i++) begin
                if (rd_req_valid_o[i] && rd_req_ready_i[i]) begin
                    requested_q[i] <= 1'b1;
                end
                // Data lands one cycle after the handshake
                if (rd_rsp_valid_i[i]) begin
                    ready_q[i] <= 1'b1;
                end
            end
            if (send) begin
                occupied_q <= 1'b0;
            end
            // New instruction overrides the per-operand flags
            if (accept) begin
                occupied_q  <= 1'b1;
                requested_q <= '0;
                // LDI needs no reads
                ready_q     <= {simt_pkg::NUM_OPS{is_ldi}};
            end
            // Execution-unit credits
            case ({send, eu_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;
            endcase
        end
    end

    // Instruction and operand payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q <= issue_i;
        end
        for (int i = 0; i < simt_pkg::NUM_OPS; i++) begin
            if (rd_rsp_valid_i[i]) begin
                data_q[i] <= rd_rsp_data_i[i];
            end
        end
    end

endmodule

//--- hw/register_file.sv
// Banked register file
// One bank per warp, two registered read ports, one lane-masked write port
`timescale 1ns/1ps

module register_file (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Read ports
    input  logic                 rd_req_valid_i [simt_pkg::NUM_OPS],
    input  simt_pkg::rf_req_t    rd_req_i       [simt_pkg::NUM_OPS],
    output logic                 rd_req_ready_o [simt_pkg::NUM_OPS],
    output logic                 rd_rsp_valid_o [simt_pkg::NUM_OPS],
    output simt_pkg::lane_data_t rd_rsp_data_o  [simt_pkg::NUM_OPS],
    // Write port
    input  logic                 wb_valid_i,
    input  simt_pkg::wb_t        wb_i
);

    // ################################################
    // Storage
    // ################################################
    simt_pkg::lane_data_t mem_q [simt_pkg::NUM_WARPS][simt_pkg::NUM_REGS];
    logic                 rd_fire [simt_pkg::NUM_OPS];

    for (genvar i = 0; i < simt_pkg::NUM_OPS; i++) begin : gen_port
        // Write wins over reads to the same warp
        assign rd_req_ready_o[i] = !(wb_valid_i && (wb_i.wid == rd_req_i[i].wid));
        assign rd_fire[i]        = rd_req_valid_i[i] && rd_req_ready_o[i];
    end

    // ################################################
    // Write port and read handshakes
    // ################################################
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // All registers start at zero
            for (int w = 0; w < simt_pkg::NUM_WARPS; w++) begin
                for (int r = 0; r < simt_pkg::NUM_REGS; r++) begin
                    mem_q[w][r] <= '0;
                end
            end
            for (int i = 0; i < simt_pkg::NUM_OPS; i++) begin
                rd_rsp_valid_o[i] <= 1'b0;
            end
        end else begin
            // Masked lanes keep their value
            if (wb_valid_i) begin
                for (int l = 0; l < simt_pkg::LANES; l++) begin
                    if (wb_i.act_mask[l]) begin
                        mem_q[wb_i.wid][wb_i.dst][l] <= wb_i.data[l];
                    end
                end
            end
            // Response one cycle after the handshake
            for (int i = 0; i < simt_pkg::NUM_OPS; i++) begin
                rd_rsp_valid_o[i] <= rd_fire[i];
            end
        end
    end

    // Read data
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < simt_pkg::NUM_OPS; i++) begin
            if (rd_fire[i]) begin
                rd_rsp_data_o[i] <= mem_q[rd_req_i[i].wid][rd_req_i[i].idx];
            end
        end
    end

endmodule

//--- hw/simt_pkg.sv
// SIMT slice shared definitions
// Sizes, opcodes, instruction encoding and pipeline payloads
package simt_pkg;

    // ################################################
    // Sizes
    // ################################################
    localparam int NUM_WARPS    = 4;
    localparam int WID_W        = 2;
    localparam int LANES        = 4;
    localparam int REG_W        = 8;
    localparam int REG_IDX_W    = 3;
    localparam int NUM_REGS     = 2 ** REG_IDX_W;
    localparam int IMM_W        = 2 * REG_IDX_W;
    localparam int TAG_W        = 3;
    localparam int NUM_OPS      = 2;

    // Credit loops and queue depths
    localparam int COLL_CREDITS = 1;
    localparam int COLL_CNT_W   = $clog2(COLL_CREDITS + 1);
    localparam int EU_CREDITS   = 2;
    localparam int EU_PTR_W     = $clog2(EU_CREDITS);
    localparam int EU_CNT_W     = $clog2(EU_CREDITS + 1);
    localparam int DISP_DEPTH   = 2;
    localparam int DISP_PTR_W   = $clog2(DISP_DEPTH);
    localparam int DISP_CNT_W   = $clog2(DISP_DEPTH + 1);

    // ################################################
    // Instruction encoding
    // ################################################
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_LDI
    } opcode_e;

    // Register view of the operand field
    typedef struct packed {
        logic [REG_IDX_W-1:0] src1;
        logic [REG_IDX_W-1:0] src0;
    } src_regs_t;

    // Same six bits, either two sources or one immediate
    typedef union packed {
        src_regs_t        regs;
        logic [IMM_W-1:0] imm;
    } operands_u;

    typedef struct packed {
        logic [WID_W-1:0]     wid;
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] dst;
        operands_u            operands;
        logic [LANES-1:0]     act_mask;
    } inst_t;

    // One register across all lanes
    typedef logic [LANES-1:0][REG_W-1:0] lane_data_t;

    // ################################################
    // Pipeline payloads
    // ################################################
    // Dispatcher to collector
    typedef struct packed {
        inst_t            inst;
        logic [TAG_W-1:0] tag;
    } issue_t;

    // Collector to execution unit
    typedef struct packed {
        issue_t     issue;
        lane_data_t src0_data;
        lane_data_t src1_data;
    } exec_t;

    // Writeback and result
    typedef struct packed {
        logic [WID_W-1:0]     wid;
        logic [REG_IDX_W-1:0] dst;
        logic [LANES-1:0]     act_mask;
        logic [TAG_W-1:0]     tag;
        lane_data_t           data;
    } wb_t;

    // Register file read request
    typedef struct packed {
        logic [WID_W-1:0]     wid;
        logic [REG_IDX_W-1:0] idx;
    } rf_req_t;

endpackage

//--- hw/simt_slice_top.sv
// SIMT compute slice
// Dispatcher, operand collector, register file and execution unit
`timescale 1ns/1ps

module simt_slice_top (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Instruction input
    input  logic            in_valid_i,
    input  simt_pkg::inst_t in_inst_i,
    output logic            in_ready_o,
    // Results
    output logic            result_valid_o,
    output simt_pkg::wb_t   result_o
);

    // ################################################
    // Interconnect
    // ################################################
    // Dispatcher to collector
    logic                 issue_valid;
    simt_pkg::issue_t     issue;
    logic                 coll_credit;
    // Collector to register file
    logic                 rd_req_valid [simt_pkg::NUM_OPS];
    simt_pkg::rf_req_t    rd_req       [simt_pkg::NUM_OPS];
    logic                 rd_req_ready [simt_pkg::NUM_OPS];
    logic                 rd_rsp_valid [simt_pkg::NUM_OPS];
    simt_pkg::lane_data_t rd_rsp_data  [simt_pkg::NUM_OPS];
    // Collector to execution unit
    logic                 exec_valid;
    simt_pkg::exec_t      exec;
    logic                 eu_credit;
    // Writeback
    logic                 wb_valid;
    simt_pkg::wb_t        wb;

    warp_dispatcher u_dispatcher (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_inst_i     (in_inst_i),
        .in_ready_o    (in_ready_o),
        .issue_valid_o (issue_valid),
        .issue_o       (issue),
        .coll_credit_i (coll_credit),
        .wb_valid_i    (wb_valid),
        .wb_i          (wb)
    );

    operand_collector u_collector (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid),
        .issue_i        (issue),
        .coll_credit_o  (coll_credit),
        .rd_req_valid_o (rd_req_valid),
        .rd_req_o       (rd_req),
        .rd_req_ready_i (rd_req_ready),
        .rd_rsp_valid_i (rd_rsp_valid),
        .rd_rsp_data_i  (rd_rsp_data),
        .exec_valid_o   (exec_valid),
        .exec_o         (exec),
        .eu_credit_i    (eu_credit)
    );

    register_file u_regfile (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rd_req_valid_i (rd_req_valid),
        .rd_req_i       (rd_req),
        .rd_req_ready_o (rd_req_ready),
        .rd_rsp_valid_o (rd_rsp_valid),
        .rd_rsp_data_o  (rd_rsp_data),
        .wb_valid_i     (wb_valid),
        .wb_i           (wb)
    );

    exec_unit u_exec (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .exec_valid_i (exec_valid),
        .exec_i       (exec),
        .eu_credit_o  (eu_credit),
        .wb_valid_o   (wb_valid),
        .wb_o         (wb)
    );

    // Results are the writeback bus
    assign result_valid_o = wb_valid;
    assign result_o       = wb;

endmodule

//--- hw/warp_dispatcher.sv
// Warp dispatcher
// Queues incoming instructions, tracks pending writes per warp, issues on credit
`timescale 1ns/1ps

module warp_dispatcher (
    input  logic             clk_i,
    input  logic             rst_n_i,
    // Instruction input
    input  logic             in_valid_i,
    input  simt_pkg::inst_t  in_inst_i,
    output logic             in_ready_o,
    // Issue toward the collector
    output logic             issue_valid_o,
    output simt_pkg::issue_t issue_o,
    input  logic             coll_credit_i,
    // Writeback clears the scoreboard
    input  logic             wb_valid_i,
    input  simt_pkg::wb_t    wb_i
);

    // ################################################
    // State
    // ################################################
    simt_pkg::issue_t                  queue_q [simt_pkg::DISP_DEPTH];
    logic [simt_pkg::DISP_PTR_W-1:0]   wr_ptr_q;
    logic [simt_pkg::DISP_PTR_W-1:0]   rd_ptr_q;
    logic [simt_pkg::DISP_CNT_W-1:0]   count_q;
    // Next tag per warp
    logic [simt_pkg::TAG_W-1:0]        tag_cnt_q [simt_pkg::NUM_WARPS];
    // One pending-write bit per register
    logic [simt_pkg::NUM_REGS-1:0]     pending_q [simt_pkg::NUM_WARPS];
    logic [simt_pkg::COLL_CNT_W-1:0]   credit_q;

    logic                              push;
    logic                              pop;
    logic                              hazard;
    simt_pkg::inst_t                   head;
    logic [simt_pkg::NUM_REGS-1:0]     head_pend;

    // ################################################
    // Hazard check on the queue head
    // ################################################
    always_comb begin
        head      = queue_q[rd_ptr_q].inst;
        head_pend = pending_q[head.wid];
        // WAW on the destination
        hazard    = head_pend[head.dst];
        // LDI has no sources to check
        if (head.opcode != simt_pkg::OP_LDI) begin
            hazard = hazard | head_pend[head.operands.regs.src0]
                            | head_pend[head.operands.regs.src1];
        end
    end

    assign in_ready_o    = count_q != simt_pkg::DISP_CNT_W'(simt_pkg::DISP_DEPTH);
    assign push          = in_valid_i && in_ready_o;
    assign issue_valid_o = (count_q != '0) && (credit_q != '0) && !hazard;
    assign pop           = issue_valid_o;
    assign issue_o       = queue_q[rd_ptr_q];

    // ################################################
    // Control state
    // ################################################
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= simt_pkg::COLL_CNT_W'(simt_pkg::COLL_CREDITS);
            for (int w = 0; w < simt_pkg::NUM_WARPS; w++) begin
                tag_cnt_q[w] <= '0;
                pending_q[w] <= '0;
            end
        end else begin
            if (push) begin
                wr_ptr_q                  <= wr_ptr_q + 1'b1;
                tag_cnt_q[in_inst_i.wid]  <= tag_cnt_q[in_inst_i.wid] + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Queue occupancy
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
            // Collector credits
            case ({pop, coll_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;
            endcase
            // Clear on writeback, set on issue, both in one cycle
            if (wb_valid_i) begin
                pending_q[wb_i.wid][wb_i.dst] <= 1'b0;
            end
            if (pop) begin
                pending_q[head.wid][head.dst] <= 1'b1;
            end
        end
    end

    // Queue storage, tag attached on entry
    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_q[wr_ptr_q] <= '{inst: in_inst_i, tag: tag_cnt_q[in_inst_i.wid]};
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the SIMT slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_simt_slice -Mdir obj_dir -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_simt_slice > sim.log 2>&1
sim_status=$?
cat sim.log

# The log decides the verdict
if grep -q "Verification failed" sim.log; then
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

exit 0

//--- test/tb_ref_model.svh
// Reference model for the SIMT slice testbench
// Register state per warp, tag counters and expected results in order
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Architectural registers as seen by accepted instructions
simt_pkg::lane_data_t       mdl_rf  [simt_pkg::NUM_WARPS][simt_pkg::NUM_REGS];
// Next tag per warp
logic [simt_pkg::TAG_W-1:0] mdl_tag [simt_pkg::NUM_WARPS];
// Results still owed by the DUT, oldest first
simt_pkg::wb_t              exp_q   [$];

// Registers and tags as after reset
task automatic model_reset();
    for (int w = 0; w < simt_pkg::NUM_WARPS; w++) begin
        mdl_tag[w] = '0;
        for (int r = 0; r < simt_pkg::NUM_REGS; r++) begin
            mdl_rf[w][r] = '0;
        end
    end
    exp_q.delete();
endtask

// Executes one accepted instruction and queues its result
task automatic model_accept(input simt_pkg::inst_t inst);
    simt_pkg::lane_data_t a;
    simt_pkg::lane_data_t b;
    simt_pkg::lane_data_t res;
    int                   sum;
    // Sources read before the destination changes
    a = mdl_rf[inst.wid][inst.operands.regs.src0];
    b = mdl_rf[inst.wid][inst.operands.regs.src1];
    for (int l = 0; l < simt_pkg::LANES; l++) begin
        case (inst.opcode)
            simt_pkg::OP_ADD: sum = int'(a[l]) + int'(b[l]);
            simt_pkg::OP_SUB: sum = int'(a[l]) - int'(b[l]) + (1 << simt_pkg::REG_W);
            simt_pkg::OP_XOR: sum = int'(a[l] ^ b[l]);
            // Immediate plus lane number for LDI
            default:          sum = int'(inst.operands.imm) + l;
        endcase
        // Wrap to the lane width
        res[l] = simt_pkg::REG_W'(sum);
    end
    // Inactive lanes keep old values
    for (int l = 0; l < simt_pkg::LANES; l++) begin
        if (inst.act_mask[l]) begin
            mdl_rf[inst.wid][inst.dst][l] = res[l];
        end
    end
    exp_q.push_back('{wid: inst.wid, dst: inst.dst, act_mask: inst.act_mask,
                      tag: mdl_tag[inst.wid], data: res});
    mdl_tag[inst.wid] = simt_pkg::TAG_W'(int'(mdl_tag[inst.wid]) + 1);
endtask

`endif

//--- test/tb_simt_slice.sv
// Testbench for the SIMT compute slice
// Random instruction stream checked against a reference model
`timescale 1ns/1ps

module tb_simt_slice;

    // ################################################
    // Test length and timing
    // ################################################
    localparam int CLK_PERIOD   = 40;
    localparam int NUM_INIT     = simt_pkg::NUM_WARPS * simt_pkg::NUM_REGS;
    localparam int NUM_RANDOM   = 400;
    // Twenty cycles per instruction is far above the worst case
    localparam int WATCHDOG_NS  = (NUM_INIT + NUM_RANDOM) * 20 * CLK_PERIOD;
    // Enough for every instruction still in flight to retire
    localparam int DRAIN_CYCLES = 100;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            in_valid;
    simt_pkg::inst_t in_inst;
    logic            in_ready;
    logic            result_valid;
    simt_pkg::wb_t   result;

    logic [31:0]     rng_state;
    simt_pkg::inst_t last_inst;
    int              num_accepted;
    int              num_results;
    int              stall_cycles;

    `include "tb_ref_model.svh"

    simt_slice_top u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .in_valid_i     (in_valid),
        .in_inst_i      (in_inst),
        .in_ready_o     (in_ready),
        .result_valid_o (result_valid),
        .result_o       (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ################################################
    // Helpers
    // ################################################
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("[FAIL] %0t ns: %s", $time, msg));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic simt_pkg::inst_t random_inst(input logic [31:0] r);
        simt_pkg::inst_t inst;
        inst.wid           = r[1:0];
        inst.opcode        = simt_pkg::opcode_e'(r[3:2]);
        inst.dst           = r[6:4];
        inst.operands.imm  = r[12:7];
        inst.act_mask      = r[16:13];
        // Quarter of the time, chain onto the previous result
        if (r[18:17] == 2'b00) begin
            inst.wid                = last_inst.wid;
            inst.operands.regs.src0 = last_inst.dst;
        end
        return inst;
    endfunction

    // Called 2 ns after an edge, returns at the same phase
    task automatic drive_inst(input simt_pkg::inst_t inst);
        logic taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_inst  = inst;
        while (!taken) begin
            // Ready only moves at the edge, so this is the value it will see
            if (in_ready) begin
                model_accept(inst);
                num_accepted++;
                taken = 1'b1;
            end else begin
                stall_cycles++;
            end
            @(posedge clk);
            #2;
        end
        in_valid  = 1'b0;
        last_inst = inst;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // ################################################
    // Result checker
    // ################################################
    // Sampled on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            assert (exp_q.size() != 0) begin
                simt_pkg::wb_t exp;
                exp = exp_q.pop_front();
                num_results++;
                assert (result == exp) else report_mismatch($sformatf(
                    "result w%0d r%0d m%h t%0d d%h, expected w%0d r%0d m%h t%0d d%h",
                    result.wid, result.dst, result.act_mask, result.tag, result.data,
                    exp.wid, exp.dst, exp.act_mask, exp.tag, exp.data));
            end else begin
                abort_run("A result appeared with no instruction outstanding");
            end
        end
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the slice stopped producing results");
    end

    // ################################################
    // Stimulus
    // ################################################
    initial begin
        simt_pkg::inst_t inst;
        logic [31:0]     r;
        int              drain_cycles;
        rng_state    = 32'h4313_be21;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_inst      = '0;
        last_inst    = '0;
        num_accepted = 0;
        num_results  = 0;
        stall_cycles = 0;
        drain_cycles = 0;
        model_reset();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Idle slice after reset
        repeat (4) begin
            @(posedge clk);
            #2;
            assert (!result_valid && in_ready) else
                abort_run("After reset the slice is not idle and ready");
        end

        // Every register of every warp gets a known value, back to back
        for (int w = 0; w < simt_pkg::NUM_WARPS; w++) begin
            for (int d = 0; d < simt_pkg::NUM_REGS; d++) begin
                r                 = next_rand();
                inst              = '0;
                inst.wid          = simt_pkg::WID_W'(w);
                inst.opcode       = simt_pkg::OP_LDI;
                inst.dst          = simt_pkg::REG_IDX_W'(d);
                inst.operands.imm = r[5:0];
                inst.act_mask     = '1;
                drive_inst(inst);
            end
        end

        // Random mix with half of the slots back to back
        for (int n = 0; n < NUM_RANDOM; n++) begin
            inst = random_inst(next_rand());
            drive_inst(inst);
            r = next_rand();
            if (r[0]) begin
                idle_cycles(int'(r[2:1]));
            end
        end

        // Bounded drain, then make sure nothing extra follows
        while (exp_q.size() != 0 && drain_cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            #2;
            drain_cycles++;
        end
        idle_cycles(10);

        assert (exp_q.size() == 0) else abort_run($sformatf(
            "Results went missing: %0d results for %0d accepted instructions",
            num_results, num_accepted));
        assert (stall_cycles != 0) else
            abort_run("in_ready_o never fell during the input bursts");
        $display("Verification passed");
        $finish;
    end

endmodule
